//--- countConnectedCore.f
+incdir+.
countConnectedPkg.sv
delayLine.sv
monotonizePipe.sv
firstBitAnalysis.sv
newSeedPipeline.sv
explorationPipeline.sv
countConnectedCore.sv
countConnectedTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --timescale 1ns/1ps \
    -f countConnectedCore.f \
    --top-module countConnectedTb \
    --Mdir obj_dir \
    -o countConnectedSim

./obj_dir/countConnectedSim | tee sim.log

if grep -qx "No errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- countConnectedRef.svh
`ifndef COUNT_CONNECTED_REF_SVH
`define COUNT_CONNECTED_REF_SVH

// points of g that lie above some point of s
function automatic graphT upWithin(graphT s, graphT g);
    graphT r;
    r = '0;
    for (int j = 0; j < GraphWidth; j++) begin
        if (g[j]) begin
            for (int i = 0; i < GraphWidth; i++) begin
                if (s[i] && ((i & j) == i)) begin
                    r[j] = 1'b1;
                end
            end
        end
    end
    return r;
endfunction

// points of g that lie below some point of s
function automatic graphT downWithin(graphT s, graphT g);
    graphT r;
    r = '0;
    for (int j = 0; j < GraphWidth; j++) begin
        if (g[j]) begin
            for (int i = 0; i < GraphWidth; i++) begin
                if (s[i] && ((i & j) == j)) begin
                    r[j] = 1'b1;
                end
            end
        end
    end
    return r;
endfunction

// removes one component after another, starting at the lowest point
function automatic countT refComponentCount(graphT g);
    graphT remaining;
    graphT comp;
    graphT prev;
    int total;
    int seedIdx;
    remaining = g;
    total = 0;
    while (remaining != '0) begin
        seedIdx = 0;
        for (int i = GraphWidth - 1; i >= 0; i--) begin
            if (remaining[i]) begin
                seedIdx = i;
            end
        end
        comp = '0;
        comp[seedIdx] = 1'b1;
        prev = '0;
        // grow until the component is closed
        while (comp != prev) begin
            prev = comp;
            comp = downWithin(upWithin(comp, remaining), remaining);
        end
        remaining = remaining & ~comp;
        total++;
    end
    return countT'(total);
endfunction

`endif

//--- countConnectedTb.sv
`timescale 1ns/1ps
`default_nettype none

module countConnectedTb;

    import countConnectedPkg::*;

    `include "countConnectedRef.svh"

    localparam int ClockPeriod = 10;
    localparam int Seed = 29242;
    localparam int FixedGraphs = 5;
    localparam int ChainGraphs = 2;
    localparam int RandomGraphs = 64;
    localparam int TotalGraphs = FixedGraphs + ChainGraphs + RandomGraphs;
    localparam int WatchdogCycles = (TotalGraphs + LoopCycles) * LoopCycles * 70;
    localparam int TagSpace = 1 << TagWidth;

    logic clk = 1'b0;
    logic rst;
    logic request;
    logic start;
    logic done;
    graphT graphIn;
    tagT tagIn;
    countT connectCount;
    tagT tagOut;

    // scoreboard indexed by tag
    countT expectedCount [TagSpace];
    bit started [TagSpace];
    bit finished [TagSpace];
    int pendingCount;
    int nextTag;

    int countErrors;
    int tagErrors;
    int resetErrors;
    int idleErrors;

    countConnectedCore u_countConnectedCore (
        .clk          (clk),
        .rst          (rst),
        .request      (request),
        .graphIn      (graphIn),
        .start        (start),
        .tagIn        (tagIn),
        .done         (done),
        .connectCount (connectCount),
        .tagOut       (tagOut)
    );

    initial begin
        forever #(ClockPeriod / 2) clk = ~clk;
    end

    task automatic checkCount(input tagT tag, input countT expected, input countT actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t: tag %0d gave count %0d, expected %0d",
                     $time, tag, actual, expected);
            countErrors++;
        end
    endtask

    task automatic checkTag(input tagT tag, output bit known);
        known = 1'b0;
        if (!started[tag]) begin
            $display("At %0t a done came back with tag %0d, which was never started", $time, tag);
            tagErrors++;
        end else if (finished[tag]) begin
            $display("At %0t tag %0d finished a second time", $time, tag);
            tagErrors++;
        end else begin
            known = 1'b1;
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin : doneMonitor
        bit known;
        if (rst === 1'b0 && done === 1'b1) begin
            checkTag(tagOut, known);
            if (known) begin
                checkCount(tagOut, expectedCount[tagOut], connectCount);
                finished[tagOut] = 1'b1;
                pendingCount--;
            end
        end
    end

    // starts on a falling edge and returns on one with start low
    task automatic launchGraph(input graphT g, input countT expected);
        tagT tag;
        tag = tagT'(nextTag);
        while (request !== 1'b1) begin
            @(negedge clk);
        end
        graphIn = g;
        tagIn = tag;
        start = 1'b1;
        expectedCount[tag] = expected;
        started[tag] = 1'b1;
        finished[tag] = 1'b0;
        pendingCount++;
        nextTag++;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic waitAllDone();
        while (pendingCount != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic checkResetBehavior();
        bit sawRequest;
        sawRequest = 1'b0;
        repeat (LoopCycles) begin
            if (done !== 1'b0) begin
                $display("At %0t done was high after reset with no graph started", $time);
                resetErrors++;
            end
            if (request === 1'b1) begin
                sawRequest = 1'b1;
            end
            @(negedge clk);
        end
        if (!sawRequest) begin
            $display("request did not rise within %0d cycles after reset", LoopCycles);
            resetErrors++;
        end
    endtask

    task automatic runKnownGraph(input graphT g, input countT expected);
        launchGraph(g, expected);
        waitAllDone();
    endtask

    task automatic testFixedGraphs();
        graphT g;
        runKnownGraph('0, countT'(0));
        g = '0;
        g[42] = 1'b1;
        runKnownGraph(g, countT'(1));
        runKnownGraph('1, countT'(1));
        g = '0;
        g[3] = 1'b1;
        g[5] = 1'b1;
        runKnownGraph(g, countT'(2));
        // every point of weight one
        g = '0;
        for (int d = 0; d < VarCount; d++) begin
            g[1 << d] = 1'b1;
        end
        runKnownGraph(g, countT'(7));
    endtask

    // zig-zag chains joined only by alternating subset and superset links
    task automatic testChainGraphs();
        int zigzag [13];
        graphT longChain;
        graphT twoChains;
        zigzag = '{1, 3, 2, 6, 4, 12, 8, 24, 16, 48, 32, 96, 64};
        longChain = '0;
        twoChains = '0;
        for (int k = 0; k < 13; k++) begin
            longChain[zigzag[k]] = 1'b1;
            // low chain on bits 0..2, high chain on bits 3..5
            if (k < 5 || (k >= 6 && k < 11)) begin
                twoChains[zigzag[k]] = 1'b1;
            end
        end
        launchGraph(longChain, refComponentCount(longChain));
        launchGraph(twoChains, refComponentCount(twoChains));
        waitAllDone();
    endtask

    function automatic graphT randomGraph();
        graphT g;
        int density;
        // sparse graphs give more components
        density = 1 + int'($urandom % 6);
        for (int i = 0; i < GraphWidth; i++) begin
            g[i] = (($urandom % 16) < density);
        end
        return g;
    endfunction

    task automatic testRandomGraphs();
        graphT g;
        for (int n = 0; n < RandomGraphs; n++) begin
            g = randomGraph();
            launchGraph(g, refComponentCount(g));
        end
        waitAllDone();
    endtask

    // with every graph finished, each slot reaching the entry is free
    // and any further done is caught by the monitor
    task automatic checkIdleSlots();
        repeat (2 * LoopCycles) begin
            if (request !== 1'b1) begin
                $display("At %0t request was low although no graph was in flight", $time);
                idleErrors++;
            end
            @(negedge clk);
        end
    endtask

    initial begin : mainSequence
        rst = 1'b1;
        start = 1'b0;
        graphIn = '0;
        tagIn = '0;
        countErrors = 0;
        tagErrors = 0;
        resetErrors = 0;
        idleErrors = 0;
        pendingCount = 0;
        nextTag = 0;
        void'($urandom(Seed));
        repeat (3) @(negedge clk);
        rst = 1'b0;

        checkResetBehavior();
        testFixedGraphs();
        testChainGraphs();
        testRandomGraphs();
        checkIdleSlots();

        $display("count errors: %0d, tag errors: %0d, reset errors: %0d, idle errors: %0d",
                 countErrors, tagErrors, resetErrors, idleErrors);
        if (countErrors + tagErrors + resetErrors + idleErrors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin : watchdog
        #(WatchdogCycles * ClockPeriod);
        $display("Timeout after %0d cycles, the run did not complete", WatchdogCycles);
        for (int t = 0; t < TagSpace; t++) begin
            if (started[t] && !finished[t]) begin
                $display("graph with tag %0d never finished", t);
            end
        end
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- countConnectedCore.sv
`timescale 1ns/1ps
`default_nettype none

module countConnectedCore (
    input  logic                     clk,
    input  logic                     rst,
    output logic                     request,
    input  countConnectedPkg::graphT graphIn,
    input  logic                     start,
    input  countConnectedPkg::tagT   tagIn,
    output logic                     done,
    output countConnectedPkg::countT connectCount,
    output countConnectedPkg::tagT   tagOut
);

    import countConnectedPkg::*;

    // values of the slot at the loop entry
    graphT leftoverRet;
    graphT extendedRet;
    logic [1:0] flagsRet;
    logic runEndRet;
    logic grabSeedRet;
    logic validRet;
    countT countRet;
    tagT tagRet;

    graphT leftoverEntry;
    logic grabEntry;
    logic validNext;
    tagT tagNext;

    // seeding stage results
    logic incrementNsd;
    graphT curExtendingNsd;
    graphT leftoverNsd;
    logic startNsd;
    countT countNsd;

    // middle register
    graphT leftoverMid;
    graphT curExtendingMid;
    countT countMid;

    // exploration results
    graphT selectedLeftover;
    graphT extendedDown;
    logic runEndExpl;
    logic grabSeedExpl;

    assign runEndRet = flagsRet[1];
    assign grabSeedRet = flagsRet[0];

    // loop entry, leftover held empty during reset
    assign leftoverEntry = rst ? '0 : (start ? graphIn : leftoverRet);
    // a freshly started slot always seeds first
    assign grabEntry = start | grabSeedRet;
    assign validNext = start | (validRet & ~runEndRet);
    assign tagNext = start ? tagIn : tagRet;

    newSeedPipeline u_newSeedPipeline (
        .clk            (clk),
        .rst            (rst),
        .graph          (leftoverEntry),
        .extendedIn     (extendedRet),
        .grabSeed       (grabEntry),
        .incrementCount (incrementNsd),
        .curExtending   (curExtendingNsd)
    );

    // bypass of the seeding stage
    delayLine #(.T(graphT), .Cycles(NewSeedDepth)) u_leftoverBypass (
        .clk(clk), .rst(rst), .din(leftoverEntry), .dout(leftoverNsd)
    );
    delayLine #(.T(logic), .Cycles(NewSeedDepth)) u_startBypass (
        .clk(clk), .rst(rst), .din(start), .dout(startNsd)
    );
    delayLine #(.T(countT), .Cycles(NewSeedDepth)) u_countBypass (
        .clk(clk), .rst(rst), .din(countRet), .dout(countNsd)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            leftoverMid <= '0;
            curExtendingMid <= '0;
            countMid <= '0;
        end else begin
            leftoverMid <= leftoverNsd;
            curExtendingMid <= curExtendingNsd;
            // new graphs count from zero
            countMid <= (startNsd ? countT'(0) : countNsd) + countT'(incrementNsd);
        end
    end

    explorationPipeline u_explorationPipeline (
        .clk              (clk),
        .rst              (rst),
        .leftover         (leftoverMid),
        .curExtending     (curExtendingMid),
        .selectedLeftover (selectedLeftover),
        .extendedDown     (extendedDown),
        .runEnd           (runEndExpl),
        .grabSeed         (grabSeedExpl)
    );

    // loop-back to the entry and to the seeding stage
    delayLine #(.T(graphT), .Cycles(LoopCycles - NewSeedDepth - 1 - ExplorationDepth))
        u_leftoverLoop (.clk(clk), .rst(rst), .din(selectedLeftover), .dout(leftoverRet));
    delayLine #(.T(logic [1:0]), .Cycles(LoopCycles - NewSeedDepth - 1 - ExplorationDepth))
        u_flagLoop (.clk(clk), .rst(rst), .din({runEndExpl, grabSeedExpl}), .dout(flagsRet));
    // extension meets the next round at the seed selection point
    delayLine #(.T(graphT), .Cycles(LoopCycles - 1 - ExplorationDownOffset))
        u_extendedLoop (.clk(clk), .rst(rst), .din(extendedDown), .dout(extendedRet));
    delayLine #(.T(countT), .Cycles(LoopCycles - NewSeedDepth - 1))
        u_countLoop (.clk(clk), .rst(rst), .din(countMid), .dout(countRet));

    // slot bookkeeping circulates the full loop
    delayLine #(.T(logic), .Cycles(LoopCycles))
        u_validLoop (.clk(clk), .rst(rst), .din(validNext), .dout(validRet));
    delayLine #(.T(tagT), .Cycles(LoopCycles))
        u_tagLoop (.clk(clk), .rst(rst), .din(tagNext), .dout(tagRet));

    // empty slot at the entry is free to take a graph
    assign request = runEndRet;
    assign done = runEndRet & validRet;
    assign connectCount = countRet;
    assign tagOut = tagRet;

endmodule

`default_nettype wire

//--- explorationPipeline.sv
`timescale 1ns/1ps
`default_nettype none

module explorationPipeline (
    input  logic                     clk,
    input  logic                     rst,
    input  countConnectedPkg::graphT leftover,
    input  countConnectedPkg::graphT curExtending,
    output countConnectedPkg::graphT selectedLeftover,
    output countConnectedPkg::graphT extendedDown,
    output logic                     runEnd,
    output logic                     grabSeed
);

    import countConnectedPkg::*;

    // leftover graph, index is the delay in cycles
    graphT leftoverPipe [1:ExplorationDepth];
    graphT midPoint [MonotonizeDepth+1:ExplorationDownOffset];

    graphT upClosed;
    graphT downClosed;
    graphT reducedDown;
    graphT reducedSum;
    graphT reducedEnd;

    logic [GraphWidth/16-1:0] reducedNonEmpty;
    logic [GraphWidth/8-1:0] chunkStable;
    logic reducedEmpty;

    monotonizePipe #(.Upward(1'b1)) u_upClose (
        .clk  (clk),
        .rst  (rst),
        .din  (curExtending),
        .dout (upClosed)
    );

    monotonizePipe #(.Upward(1'b0)) u_downClose (
        .clk  (clk),
        .rst  (rst),
        .din  (midPoint[MonotonizeDepth+1]),
        .dout (downClosed)
    );

    // extension and reduction at the down stage
    assign extendedDown = leftoverPipe[ExplorationDownOffset] & downClosed;
    assign reducedDown = leftoverPipe[ExplorationDownOffset] & ~downClosed;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 1; k <= ExplorationDepth; k++) begin
                leftoverPipe[k] <= '0;
            end
            for (int k = MonotonizeDepth + 1; k <= ExplorationDownOffset; k++) begin
                midPoint[k] <= '0;
            end
            reducedNonEmpty <= '0;
            chunkStable <= '0;
            reducedSum <= '0;
            reducedEnd <= '0;
            runEnd <= 1'b0;
            grabSeed <= 1'b0;
        end else begin
            leftoverPipe[1] <= leftover;
            for (int k = 2; k <= ExplorationDepth; k++) begin
                leftoverPipe[k] <= leftoverPipe[k - 1];
            end

            // up-closure kept inside the graph
            midPoint[MonotonizeDepth+1] <= upClosed & leftoverPipe[MonotonizeDepth];
            for (int k = MonotonizeDepth + 2; k <= ExplorationDownOffset; k++) begin
                midPoint[k] <= midPoint[k - 1];
            end

            // partial zero and equality checks
            for (int g = 0; g < GraphWidth / 16; g++) begin
                reducedNonEmpty[g] <= |reducedDown[16*g +: 16];
            end
            for (int c = 0; c < GraphWidth / 8; c++) begin
                chunkStable[c] <= extendedDown[8*c +: 8] == midPoint[ExplorationDownOffset][8*c +: 8];
            end
            reducedSum <= reducedDown;

            runEnd <= reducedEmpty;
            // Stable extension means the component is complete.
            // An empty remainder ends the run even if the extension still grew.
            grabSeed <= reducedEmpty | (&chunkStable);
            reducedEnd <= reducedSum;
        end
    end

    assign reducedEmpty = ~(|reducedNonEmpty);

    // component removed only once it is complete
    assign selectedLeftover = grabSeed ? reducedEnd : leftoverPipe[ExplorationDepth];

endmodule

`default_nettype wire

//--- newSeedPipeline.sv
`timescale 1ns/1ps
`default_nettype none

module newSeedPipeline (
    input  logic                     clk,
    input  logic                     rst,
    input  countConnectedPkg::graphT graph,
    input  countConnectedPkg::graphT extendedIn,
    input  logic                     grabSeed,
    output logic                     incrementCount,
    output countConnectedPkg::graphT curExtending
);

    import countConnectedPkg::*;

    graphT graphStart;
    logic grabStart;
    graphT graphAligned;
    logic grabAligned;

    logic [1:0] hasBit64;
    logic [31:0] hasFirstBit4;
    logic [7:0] hasFirstBit16;

    logic [GraphWidth/4-1:0] firstNibble;
    graphT seed;

    // entry register ahead of the analysis tree
    always_ff @(posedge clk) begin
        if (rst) begin
            graphStart <= '0;
            grabStart <= 1'b0;
        end else begin
            graphStart <= graph;
            grabStart <= grabSeed;
        end
    end

    firstBitAnalysis u_firstBitAnalysis (
        .clk           (clk),
        .rst           (rst),
        .graph         (graphStart),
        .hasBit64      (hasBit64),
        .hasFirstBit4  (hasFirstBit4),
        .hasFirstBit16 (hasFirstBit16)
    );

    delayLine #(.T(graphT), .Cycles(HasBitDepth)) u_graphDelay (
        .clk  (clk),
        .rst  (rst),
        .din  (graphStart),
        .dout (graphAligned)
    );

    delayLine #(.T(logic), .Cycles(HasBitDepth)) u_grabDelay (
        .clk  (clk),
        .rst  (rst),
        .din  (grabStart),
        .dout (grabAligned)
    );

    // the nibble holding the overall first bit, then its lowest bit
    always_comb begin
        for (int n = 0; n < GraphWidth / 4; n++) begin
            firstNibble[n] = hasFirstBit4[n] & hasFirstBit16[n/4] & ((n < 16) | ~hasBit64[0]);
            seed[4*n +: 4] = firstNibble[n] ? lowestBit4(graphAligned[4*n +: 4]) : 4'b0000;
        end
    end

    assign curExtending = grabAligned ? seed : extendedIn;

    // an empty graph yields no seed and no new component
    assign incrementCount = grabAligned & (|hasBit64);

endmodule

`default_nettype wire

//--- firstBitAnalysis.sv
`timescale 1ns/1ps
`default_nettype none

module firstBitAnalysis (
    input  logic                     clk,
    input  logic                     rst,
    input  countConnectedPkg::graphT graph,
    output logic [1:0]               hasBit64,
    output logic [31:0]              hasFirstBit4,
    output logic [7:0]               hasFirstBit16
);

    import countConnectedPkg::*;

    logic [GraphWidth/4-1:0]  hasBit4;
    logic [GraphWidth/16-1:0] hasBit16;
    // first-nibble marks, one cycle early
    logic [GraphWidth/4-1:0]  firstBit4Early;

    always_ff @(posedge clk) begin
        if (rst) begin
            hasBit4 <= '0;
            hasBit16 <= '0;
            firstBit4Early <= '0;
            hasBit64 <= '0;
            hasFirstBit16 <= '0;
            hasFirstBit4 <= '0;
        end else begin
            // stage 1: any bit per nibble
            for (int n = 0; n < GraphWidth / 4; n++) begin
                hasBit4[n] <= |graph[4*n +: 4];
            end

            // stage 2: 16-bit groups, and which nibble leads each group
            for (int g = 0; g < GraphWidth / 16; g++) begin
                hasBit16[g] <= |hasBit4[4*g +: 4];
                firstBit4Early[4*g +: 4] <= lowestBit4(hasBit4[4*g +: 4]);
            end

            // stage 3: halves, and which group leads each half
            for (int h = 0; h < GraphWidth / 64; h++) begin
                hasBit64[h] <= |hasBit16[4*h +: 4];
                hasFirstBit16[4*h +: 4] <= lowestBit4(hasBit16[4*h +: 4]);
            end
            hasFirstBit4 <= firstBit4Early;
        end
    end

endmodule

`default_nettype wire

//--- monotonizePipe.sv
`timescale 1ns/1ps
`default_nettype none

module monotonizePipe #(
    parameter bit Upward = 1'b1
) (
    input  logic                     clk,
    input  logic                     rst,
    input  countConnectedPkg::graphT din,
    output countConnectedPkg::graphT dout
);

    import countConnectedPkg::*;

    graphT halfClosed;

    // closure along dimensions firstDim..lastDim, one dimension after the other
    function automatic graphT closeDims(graphT g, int firstDim, int lastDim);
        graphT acc;
        graphT prev;
        acc = g;
        for (int d = firstDim; d <= lastDim; d++) begin
            prev = acc;
            for (int i = 0; i < GraphWidth; i++) begin
                if (Upward && ((i >> d) & 1) == 1) begin
                    // point takes its subset along d
                    acc[i] = prev[i] | prev[i ^ (1 << d)];
                end else if (!Upward && ((i >> d) & 1) == 0) begin
                    // point takes its superset along d
                    acc[i] = prev[i] | prev[i | (1 << d)];
                end
            end
        end
        return acc;
    endfunction

    // dims 0..3 first, the remaining three in the second stage
    always_ff @(posedge clk) begin
        if (rst) begin
            halfClosed <= '0;
            dout <= '0;
        end else begin
            halfClosed <= closeDims(din, 0, 3);
            dout <= closeDims(halfClosed, 4, VarCount - 1);
        end
    end

endmodule

`default_nettype wire

//--- delayLine.sv
`timescale 1ns/1ps
`default_nettype none

module delayLine #(
    parameter type T = logic,
    parameter int Cycles = 1
) (
    input  logic clk,
    input  logic rst,
    input  T     din,
    output T     dout
);

    generate
        if (Cycles == 0) begin : gPass
            // zero length, value passes in the same cycle
            assign dout = din;
        end else begin : gShift
            T stages [Cycles];

            always_ff @(posedge clk) begin
                if (rst) begin
                    for (int k = 0; k < Cycles; k++) begin
                        stages[k] <= '0;
                    end
                end else begin
                    stages[0] <= din;
                    for (int k = 1; k < Cycles; k++) begin
                        stages[k] <= stages[k - 1];
                    end
                end
            end

            assign dout = stages[Cycles - 1];
        end
    endgenerate

endmodule

`default_nettype wire

//--- countConnectedPkg.sv
`default_nettype none

package countConnectedPkg;

    // graph is the truth table over the hypercube points
    localparam int VarCount = 7;
    localparam int GraphWidth = 1 << VarCount;
    typedef logic [GraphWidth-1:0] graphT;

    // component count and caller tag
    localparam int CountWidth = 6;
    typedef logic [CountWidth-1:0] countT;

    localparam int TagWidth = 10;
    typedef logic [TagWidth-1:0] tagT;

    // latencies of the pipeline blocks
    localparam int HasBitDepth = 3;
    localparam int NewSeedDepth = 4;
    localparam int MonotonizeDepth = 2;
    localparam int ExplorationDepth = 7;
    localparam int ExplorationDownOffset = 5;

    // seeding, one middle register, exploration
    // equals the number of slots in flight
    localparam int LoopCycles = NewSeedDepth + 1 + ExplorationDepth;

    // one-hot of the lowest set bit in a nibble
    function automatic logic [3:0] lowestBit4(logic [3:0] v);
        return v & (~v + 4'd1);
    endfunction

endpackage

`default_nettype wire
